// ==== filelist.f ====
+incdir+hdl
hdl/l2_pkg.sv
hdl/l2_tagv.sv
hdl/l2_dirty_table.sv
hdl/l2_data.sv
hdl/l2_plru.sv
hdl/l2_fsm.sv
hdl/l2cache.sv
testbench/tb_mem_model.sv
testbench/l2cache_tb.sv

// ==== hdl/l2_config.svh ====
`ifndef L2_CONFIG_SVH
`define L2_CONFIG_SVH

// cache geometry
// four sets, eight-word lines, four ways

// set-index bits
`define L2_INDEX_WIDTH 2

// word offset within an L2 line
`define L2_OFFSET_WIDTH 3

// word offset within an L1 line
`define L2_L1_OFFSET_WIDTH 2

// number of ways, the PLRU tree assumes four
`define L2_WAYS 4

// remaining upper address bits form the tag
`define L2_TAG_WIDTH (32 - `L2_INDEX_WIDTH - `L2_OFFSET_WIDTH - 2)

`endif

// ==== hdl/l2_data.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2_data (
    input  logic                        clk,
    input  logic [`L2_INDEX_WIDTH-1:0]  rd_index,
    output l2_pkg::line_t               rd_lines [`L2_WAYS],
    input  logic [`L2_INDEX_WIDTH-1:0]  wr_index,
    input  l2_pkg::way_mask_t           we,
    input  logic                        refill,
    input  l2_pkg::line_t               refill_line,
    input  logic [`L2_OFFSET_WIDTH-1:0] word_offset,
    input  logic [31:0]                 word_data,
    input  logic [3:0]                  word_strb
);
    localparam int SETS = 1 << `L2_INDEX_WIDTH;

    l2_pkg::line_t line_mem [`L2_WAYS][SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (we[w]) begin
                if (refill) begin
                    // whole line from memory
                    line_mem[w][wr_index] <= refill_line;
                end else begin
                    // single store word under byte strobe
                    for (int b = 0; b < 4; b++) begin
                        if (word_strb[b]) begin
                            line_mem[w][wr_index][word_offset*32 + b*8 +: 8] <=
                                word_data[b*8 +: 8];
                        end
                    end
                end
            end
            rd_lines[w] <= line_mem[w][rd_index];
        end
    end

endmodule

// ==== hdl/l2_dirty_table.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2_dirty_table (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`L2_INDEX_WIDTH-1:0] index,
    input  l2_pkg::way_idx_t           way,
    input  logic                       set_dirty,
    input  logic                       clear_dirty,
    output logic                       dirty
);
    localparam int SETS = 1 << `L2_INDEX_WIDTH;

    l2_pkg::way_mask_t dirty_bits [SETS];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                dirty_bits[s] <= '0;
            end
        end else if (set_dirty) begin
            dirty_bits[index][way] <= 1'b1;
        end else if (clear_dirty) begin
            dirty_bits[index][way] <= 1'b0;
        end
    end

    // bit of the addressed way
    assign dirty = dirty_bits[index][way];

    // store hits and refills are distinct FSM events
    set_clear_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(set_dirty && clear_dirty));

endmodule

// ==== hdl/l2_fsm.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2_fsm (
    input  logic              clk,
    input  logic              rstn,
    input  l2_pkg::req_src_t  src,
    output logic              capture,
    input  l2_pkg::req_src_t  buf_src,
    input  l2_pkg::way_mask_t hit,
    input  logic              dirty,
    input  l2_pkg::way_idx_t  victim,
    output logic              icache_addr_ok,
    output logic              icache_data_ok,
    output logic              dcache_addr_ok,
    output logic              dcache_data_ok,
    output logic              mem_req_r,
    input  logic              mem_addr_ok_r,
    output logic              mem_req_w,
    input  logic              mem_addr_ok_w,
    input  logic              mem_data_ok,
    output l2_pkg::way_mask_t data_we,
    output logic              data_refill,
    output l2_pkg::way_mask_t tag_we,
    output l2_pkg::way_idx_t  sel_way,
    output logic              sel_refill,
    output logic              set_dirty,
    output logic              clear_dirty,
    output logic              touch
);
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_wb_req,
        st_wb_wait,
        st_rf_req,
        st_rf_wait,
        st_respond
    } state_t;

    state_t            state;
    state_t            state_next;
    l2_pkg::way_idx_t  victim_q;
    l2_pkg::way_idx_t  hit_way;
    l2_pkg::way_mask_t sel_mask;
    logic              is_hit;
    logic              is_store;
    logic              store_hit;
    logic              refill_done;
    logic              data_ok;

    assign is_hit   = |hit;
    assign is_store = (buf_src == l2_pkg::src_dwrite);

    // encode the one-hot hit mask
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (hit[w]) begin
                hit_way = l2_pkg::way_idx_t'(w);
            end
        end
    end

    // live way during lookup and the latched victim afterwards
    assign sel_way  = (state == st_lookup) ? (is_hit ? hit_way : victim) : victim_q;
    assign sel_mask = l2_pkg::way_mask_t'(1) << sel_way;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (src != l2_pkg::src_none) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                if (is_hit) begin
                    state_next = st_idle;
                end else if (dirty) begin
                    state_next = st_wb_req;
                end else begin
                    state_next = st_rf_req;
                end
            end
            st_wb_req: begin
                if (mem_addr_ok_w) begin
                    state_next = st_wb_wait;
                end
            end
            st_wb_wait: begin
                if (mem_data_ok) begin
                    state_next = st_rf_req;
                end
            end
            st_rf_req: begin
                if (mem_addr_ok_r) begin
                    state_next = st_rf_wait;
                end
            end
            st_rf_wait: begin
                if (mem_data_ok) begin
                    state_next = st_respond;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= st_idle;
            victim_q <= '0;
        end else begin
            state <= state_next;
            if (state == st_lookup && !is_hit) begin
                victim_q <= victim;
            end
        end
    end

    // L1 handshakes
    assign capture        = (state == st_idle) && (src != l2_pkg::src_none);
    assign icache_addr_ok = capture && (src == l2_pkg::src_icache);
    assign dcache_addr_ok = capture && (src != l2_pkg::src_icache);
    assign data_ok        = ((state == st_lookup) && is_hit) || (state == st_respond);
    assign icache_data_ok = data_ok && (buf_src == l2_pkg::src_icache);
    assign dcache_data_ok = data_ok && (buf_src == l2_pkg::src_dread || is_store);

    // memory handshakes
    assign mem_req_w = (state == st_wb_req);
    assign mem_req_r = (state == st_rf_req);

    // array updates
    assign store_hit   = (state == st_lookup) && is_hit && is_store;
    assign refill_done = (state == st_rf_wait) && mem_data_ok;
    assign data_we     = (store_hit || refill_done) ? sel_mask : '0;
    assign data_refill = refill_done;
    assign tag_we      = refill_done ? sel_mask : '0;
    assign sel_refill  = (state == st_respond);
    assign set_dirty   = store_hit || (refill_done && is_store);
    assign clear_dirty = refill_done && !is_store;
    assign touch       = ((state == st_lookup) && is_hit) || refill_done;

    // a new grant only once the previous request has been answered
    addr_ok_in_idle: assert property (@(posedge clk) disable iff (!rstn)
        (icache_addr_ok || dcache_addr_ok) |->
            $past(data_ok || (state == st_idle && !capture)));

    mem_req_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req_r && mem_req_w));

endmodule

// ==== hdl/l2_pkg.sv ====
`include "l2_config.svh"

package l2_pkg;

    // one full L2 line, 8 words
    typedef logic [(32 << `L2_OFFSET_WIDTH)-1:0] line_t;

    // one L1 line, 4 words
    typedef logic [(32 << `L2_L1_OFFSET_WIDTH)-1:0] l1_line_t;

    // address tag
    typedef logic [`L2_TAG_WIDTH-1:0] tag_t;

    // one bit per way
    typedef logic [`L2_WAYS-1:0] way_mask_t;

    // encoded way number
    typedef logic [1:0] way_idx_t;

    // who issued the buffered request
    typedef enum logic [1:0] {
        src_none   = 2'd0,
        src_icache = 2'd1,
        src_dread  = 2'd2,
        src_dwrite = 2'd3
    } req_src_t;

endpackage

// ==== hdl/l2_plru.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2_plru (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`L2_INDEX_WIDTH-1:0] index,
    input  l2_pkg::way_mask_t          valid,
    input  logic                       touch,
    input  l2_pkg::way_idx_t           touch_way,
    output l2_pkg::way_idx_t           victim
);
    localparam int SETS = 1 << `L2_INDEX_WIDTH;

    // bit 0 root (1 = right pair), bit 1 left pair, bit 2 right pair
    logic [2:0] tree [SETS];
    logic [2:0] cur;

    assign cur = tree[index];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            // point every node on the path away from the used way
            tree[index][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree[index][2] <= ~touch_way[0];
            end else begin
                tree[index][1] <= ~touch_way[0];
            end
        end
    end

    always_comb begin
        victim = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
        // an empty way wins, lowest first
        for (int w = `L2_WAYS-1; w >= 0; w--) begin
            if (!valid[w]) begin
                victim = l2_pkg::way_idx_t'(w);
            end
        end
    end

endmodule

// ==== hdl/l2_tagv.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2_tagv (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`L2_INDEX_WIDTH-1:0] rd_index,
    input  l2_pkg::tag_t               cmp_tag,
    output l2_pkg::way_mask_t          hit,
    output l2_pkg::way_mask_t          valid,
    input  l2_pkg::way_idx_t           victim_way,
    output l2_pkg::tag_t               victim_tag,
    input  logic [`L2_INDEX_WIDTH-1:0] wr_index,
    input  l2_pkg::tag_t               wr_tag,
    input  l2_pkg::way_mask_t          we
);
    localparam int SETS = 1 << `L2_INDEX_WIDTH;

    l2_pkg::tag_t      tag_mem [`L2_WAYS][SETS];
    l2_pkg::way_mask_t valid_bits [SETS];
    l2_pkg::tag_t      rd_tag [`L2_WAYS];

    // tag ram per way, synchronous read
    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (we[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    // valid bits, every set cleared in reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                valid_bits[s] <= '0;
            end
            valid <= '0;
        end else begin
            valid_bits[wr_index] <= valid_bits[wr_index] | we;
            valid <= valid_bits[rd_index];
        end
    end

    // parallel compare against the buffered tag
    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            hit[w] = valid[w] && (rd_tag[w] == cmp_tag);
        end
    end

    // tag of the line about to be written back
    assign victim_tag = rd_tag[victim_way];

    // a refill only ever installs a tag that missed in its set
    hit_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit));

endmodule

// ==== hdl/l2cache.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2cache (
    input  logic             clk,
    input  logic             rstn,
    input  logic             icache_req,
    input  logic [31:0]      icache_addr,
    output logic             icache_addr_ok,
    output logic             icache_data_ok,
    output l2_pkg::l1_line_t icache_rdata,
    input  logic             dcache_req,
    input  logic             dcache_wr,
    input  logic [31:0]      dcache_addr,
    input  logic [31:0]      dcache_wdata,
    input  logic [3:0]       dcache_wstrb,
    output logic             dcache_addr_ok,
    output logic             dcache_data_ok,
    output l2_pkg::l1_line_t dcache_rdata,
    output logic             mem_req_r,
    output logic [31:0]      mem_addr_r,
    input  logic             mem_addr_ok_r,
    output logic             mem_req_w,
    output logic [31:0]      mem_addr_w,
    output l2_pkg::line_t    mem_wdata,
    input  logic             mem_addr_ok_w,
    input  logic             mem_data_ok,
    input  l2_pkg::line_t    mem_rdata
);
    localparam int IDX_LO  = `L2_OFFSET_WIDTH + 2;
    localparam int TAG_LO  = `L2_OFFSET_WIDTH + `L2_INDEX_WIDTH + 2;
    localparam int HALF_LO = `L2_L1_OFFSET_WIDTH + 2;
    localparam int L1_BITS = 32 << `L2_L1_OFFSET_WIDTH;

    l2_pkg::req_src_t  src;
    l2_pkg::req_src_t  buf_src;
    logic [31:0]       req_addr;
    logic [31:0]       buf_addr;
    logic [31:0]       buf_wdata;
    logic [3:0]        buf_strb;
    logic              capture;
    logic [`L2_INDEX_WIDTH-1:0] buf_index;
    logic [`L2_INDEX_WIDTH-1:0] rd_index;
    logic [`L2_OFFSET_WIDTH-1:0] buf_offset;
    logic [`L2_OFFSET_WIDTH-`L2_L1_OFFSET_WIDTH-1:0] buf_half;
    l2_pkg::tag_t      buf_tag;
    l2_pkg::tag_t      victim_tag;
    l2_pkg::way_mask_t hit;
    l2_pkg::way_mask_t valid;
    l2_pkg::way_mask_t data_we;
    l2_pkg::way_mask_t tag_we;
    l2_pkg::way_idx_t  victim;
    l2_pkg::way_idx_t  sel_way;
    logic              dirty;
    logic              data_refill;
    logic              sel_refill;
    logic              set_dirty;
    logic              clear_dirty;
    logic              touch;
    l2_pkg::line_t     rd_lines [`L2_WAYS];
    l2_pkg::line_t     refill_q;
    l2_pkg::line_t     refill_line;
    l2_pkg::line_t     sel_line;

    // data side wins when both L1s request
    always_comb begin
        if (dcache_req) begin
            src      = dcache_wr ? l2_pkg::src_dwrite : l2_pkg::src_dread;
            req_addr = dcache_addr;
        end else begin
            src      = icache_req ? l2_pkg::src_icache : l2_pkg::src_none;
            req_addr = icache_addr;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_src <= l2_pkg::src_none;
        end else if (capture) begin
            buf_src <= src;
        end
        if (capture) begin
            buf_addr  <= req_addr;
            buf_wdata <= dcache_wdata;
            buf_strb  <= dcache_wstrb;
        end
    end

    assign buf_offset = buf_addr[IDX_LO-1:2];
    assign buf_half   = buf_addr[IDX_LO-1:HALF_LO];
    assign buf_index  = buf_addr[TAG_LO-1:IDX_LO];
    assign buf_tag    = buf_addr[31:TAG_LO];

    // incoming index on capture so lookup sees the arrays next cycle
    assign rd_index = capture ? req_addr[TAG_LO-1:IDX_LO] : buf_index;

    always_ff @(posedge clk) begin
        if (mem_data_ok) begin
            refill_q <= mem_rdata;
        end
    end

    // store word merged into the incoming line on a write miss
    always_comb begin
        refill_line = mem_rdata;
        if (buf_src == l2_pkg::src_dwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (buf_strb[b]) begin
                    refill_line[buf_offset*32 + b*8 +: 8] = buf_wdata[b*8 +: 8];
                end
            end
        end
    end

    // output steering
    assign sel_line     = sel_refill ? refill_q : rd_lines[sel_way];
    assign icache_rdata = sel_line[buf_half*L1_BITS +: L1_BITS];
    assign dcache_rdata = sel_line[buf_half*L1_BITS +: L1_BITS];
    assign mem_wdata    = rd_lines[sel_way];
    assign mem_addr_r   = {buf_addr[31:IDX_LO], {IDX_LO{1'b0}}};
    assign mem_addr_w   = {victim_tag, buf_index, {IDX_LO{1'b0}}};

    l2_tagv tagv0 (
        .clk(clk), .rstn(rstn), .rd_index(rd_index), .cmp_tag(buf_tag),
        .hit(hit), .valid(valid), .victim_way(sel_way), .victim_tag(victim_tag),
        .wr_index(buf_index), .wr_tag(buf_tag), .we(tag_we)
    );

    l2_dirty_table dirty0 (
        .clk(clk), .rstn(rstn), .index(buf_index), .way(sel_way),
        .set_dirty(set_dirty), .clear_dirty(clear_dirty), .dirty(dirty)
    );

    l2_data data0 (
        .clk(clk), .rd_index(rd_index), .rd_lines(rd_lines), .wr_index(buf_index),
        .we(data_we), .refill(data_refill), .refill_line(refill_line),
        .word_offset(buf_offset), .word_data(buf_wdata), .word_strb(buf_strb)
    );

    l2_plru plru0 (
        .clk(clk), .rstn(rstn), .index(buf_index), .valid(valid),
        .touch(touch), .touch_way(sel_way), .victim(victim)
    );

    l2_fsm fsm0 (
        .clk(clk), .rstn(rstn), .src(src), .capture(capture), .buf_src(buf_src),
        .hit(hit), .dirty(dirty), .victim(victim),
        .icache_addr_ok(icache_addr_ok), .icache_data_ok(icache_data_ok),
        .dcache_addr_ok(dcache_addr_ok), .dcache_data_ok(dcache_data_ok),
        .mem_req_r(mem_req_r), .mem_addr_ok_r(mem_addr_ok_r),
        .mem_req_w(mem_req_w), .mem_addr_ok_w(mem_addr_ok_w), .mem_data_ok(mem_data_ok),
        .data_we(data_we), .data_refill(data_refill), .tag_we(tag_we), .sel_way(sel_way),
        .sel_refill(sel_refill), .set_dirty(set_dirty), .clear_dirty(clear_dirty),
        .touch(touch)
    );

endmodule

// ==== testbench/l2cache_tb.sv ====
`timescale 1ns/1ps

module l2cache_tb;
    // worst miss is a writeback plus a refill under the longest memory delays
    localparam int NUM_OPS    = 100;
    localparam int WORST_MISS = 30;
    localparam int TIMEOUT_NS = (NUM_OPS * WORST_MISS + 100) * 20;

    logic             clk;
    logic             rstn;
    logic             icache_req;
    logic [31:0]      icache_addr;
    logic             icache_addr_ok;
    logic             icache_data_ok;
    l2_pkg::l1_line_t icache_rdata;
    logic             dcache_req;
    logic             dcache_wr;
    logic [31:0]      dcache_addr;
    logic [31:0]      dcache_wdata;
    logic [3:0]       dcache_wstrb;
    logic             dcache_addr_ok;
    logic             dcache_data_ok;
    l2_pkg::l1_line_t dcache_rdata;
    logic             mem_req_r;
    logic [31:0]      mem_addr_r;
    logic             mem_addr_ok_r;
    logic             mem_req_w;
    logic [31:0]      mem_addr_w;
    l2_pkg::line_t    mem_wdata;
    logic             mem_addr_ok_w;
    logic             mem_data_ok;
    l2_pkg::line_t    mem_rdata;

    // shadow of memory with every store applied
    logic [31:0] shadow [logic [31:0]];

    logic [31:0] d_addr;
    logic [31:0] i_addr;
    logic [31:0] cur_addr;
    logic        d_read;
    logic        saw_mem_r;
    int          cycle;
    int          accept_cycle;
    int          latency;
    int          resp_count;
    int          wb_count;
    int          reads_checked;
    int          data_errors;
    int          proto_errors;

    l2cache dut0 (.*);

    tb_mem_model mem0 (
        .clk(clk), .mem_req_r(mem_req_r), .mem_addr_r(mem_addr_r),
        .mem_addr_ok_r(mem_addr_ok_r), .mem_req_w(mem_req_w), .mem_addr_w(mem_addr_w),
        .mem_wdata(mem_wdata), .mem_addr_ok_w(mem_addr_ok_w),
        .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5ac3_0f1e;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return fill_word(addr);
    endfunction

    // expected read data is the four words of the L1 line holding addr
    function automatic l2_pkg::l1_line_t expected_line(input logic [31:0] addr);
        l2_pkg::l1_line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = shadow_word({addr[31:4], 4'h0} + 32'(w * 4));
        end
        return line;
    endfunction

    task automatic apply_store(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [31:0] word;
        word = shadow_word({addr[31:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        shadow[{addr[31:2], 2'b00}] = word;
    endtask

    task automatic check_line(input string name, input logic [31:0] addr,
                              input l2_pkg::l1_line_t got);
        l2_pkg::l1_line_t exp;
        exp = expected_line(addr);
        reads_checked++;
        assert (got === exp) else begin
            data_errors++;
            $display("FAIL %s addr %h: got %h expected %h", name, addr, got, exp);
        end
    endtask

    // a dirty victim lies in the requested set under another tag
    task automatic check_writeback();
        l2_pkg::line_t exp;
        for (int w = 0; w < 8; w++) begin
            exp[w*32 +: 32] = shadow_word(mem_addr_w + 32'(w * 4));
        end
        wb_count++;
        assert (mem_addr_w[6:0] === {cur_addr[6:5], 5'h0}
                && mem_addr_w[31:7] !== cur_addr[31:7]) else begin
            data_errors++;
            $display("FAIL mem_addr_w: got %h for a miss at %h", mem_addr_w, cur_addr);
        end
        assert (mem_wdata === exp) else begin
            data_errors++;
            $display("FAIL mem_wdata addr %h: got %h expected %h", mem_addr_w, mem_wdata, exp);
        end
    endtask

    // outputs are compared at the falling edge where they have settled
    always @(negedge clk) begin
        if (rstn) begin
            cycle++;
            if (icache_addr_ok || dcache_addr_ok) begin
                accept_cycle = cycle;
                saw_mem_r    = 1'b0;
                cur_addr     = dcache_addr_ok ? dcache_addr : icache_addr;
            end
            if (mem_req_r) begin
                saw_mem_r = 1'b1;
            end
            if (mem_req_r && mem_addr_ok_r) begin
                assert (mem_addr_r === {cur_addr[31:5], 5'h0}) else begin
                    data_errors++;
                    $display("FAIL mem_addr_r: got %h expected %h", mem_addr_r,
                             {cur_addr[31:5], 5'h0});
                end
            end
            if (mem_req_w && mem_addr_ok_w) begin
                check_writeback();
            end
            assert (!(icache_data_ok && dcache_data_ok)) else begin
                proto_errors++;
                $display("both L1 sides received data_ok in the same cycle");
            end
            if (dcache_data_ok) begin
                if (d_read) begin
                    check_line("dcache_rdata", d_addr, dcache_rdata);
                end
                latency = cycle - accept_cycle;
                resp_count++;
            end
            if (icache_data_ok) begin
                check_line("icache_rdata", i_addr, icache_rdata);
                latency = cycle - accept_cycle;
                resp_count++;
            end
        end
    end

    // one request from one side that returns 2 ns after the edge following data_ok
    task automatic access(input logic icache_side, input logic wr, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb);
        int n;
        n = resp_count;
        if (icache_side) begin
            i_addr      = addr;
            icache_addr = addr;
            icache_req  = 1'b1;
        end else begin
            d_addr       = addr;
            d_read       = !wr;
            dcache_addr  = addr;
            dcache_wr    = wr;
            dcache_wdata = wdata;
            dcache_wstrb = strb;
            dcache_req   = 1'b1;
            if (wr) begin
                apply_store(addr, wdata, strb);
            end
        end
        @(negedge clk);
        while (!(icache_addr_ok || dcache_addr_ok)) @(negedge clk);
        @(posedge clk);
        #2;
        icache_req = 1'b0;
        dcache_req = 1'b0;
        while (resp_count == n) @(posedge clk);
        #2;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!(icache_addr_ok || dcache_addr_ok || icache_data_ok || dcache_data_ok
                      || mem_req_r || mem_req_w)) else begin
                proto_errors++;
                $display("handshake output active after reset with no request pending");
            end
        end
        @(posedge clk);
        #2;
    endtask

    task automatic store_then_load();
        logic [31:0] addr;
        addr = 32'($urandom_range(0, 4095)) << 2;
        access(1'b0, 1'b1, addr, $urandom, 4'($urandom_range(1, 15)));
        access(1'b0, 1'b0, addr, '0, '0);
        access(1'b1, 1'b0, addr, '0, '0);
    endtask

    // six dirty tags in set 2 of a four-way cache
    task automatic evict_set();
        logic [31:0] base;
        int          wb_before;
        wb_before = wb_count;
        for (int t = 0; t < 6; t++) begin
            base = 32'h1040 + 32'(t) * 32'h80;
            access(1'b0, 1'b1, base | (32'($urandom_range(7)) << 2), $urandom,
                   4'($urandom_range(1, 15)));
        end
        for (int t = 0; t < 6; t++) begin
            base = 32'h1040 + 32'(t) * 32'h80;
            access(1'b0, 1'b0, base, '0, '0);
            access(1'b0, 1'b0, base | 32'h10, '0, '0);
        end
        assert (wb_count - wb_before >= 2) else begin
            proto_errors++;
            $display("too few writebacks while evicting dirty lines from one set");
        end
    endtask

    task automatic dual_request(input logic [31:0] da, input logic [31:0] ia);
        int n;
        n            = resp_count;
        d_addr       = da;
        d_read       = 1'b1;
        i_addr       = ia;
        dcache_addr  = da;
        dcache_wr    = 1'b0;
        dcache_req   = 1'b1;
        icache_addr  = ia;
        icache_req   = 1'b1;
        @(negedge clk);
        while (!(icache_addr_ok || dcache_addr_ok)) @(negedge clk);
        assert (dcache_addr_ok && !icache_addr_ok) else begin
            proto_errors++;
            $display("instruction request was granted ahead of the data request");
        end
        @(posedge clk);
        #2;
        dcache_req = 1'b0;
        // instruction side keeps requesting until its turn
        @(negedge clk);
        while (!icache_addr_ok) @(negedge clk);
        @(posedge clk);
        #2;
        icache_req = 1'b0;
        while (resp_count < n + 2) @(posedge clk);
        #2;
    endtask

    task automatic random_mix(input int count);
        logic [31:0] addr;
        int          kind;
        for (int k = 0; k < count; k++) begin
            // 1 KB window gives eight tags per set
            addr = 32'($urandom_range(0, 255)) << 2;
            kind = $urandom_range(2);
            case (kind)
                0: access(1'b1, 1'b0, addr, '0, '0);
                1: access(1'b0, 1'b0, addr, '0, '0);
                default: access(1'b0, 1'b1, addr, $urandom, 4'($urandom_range(1, 15)));
            endcase
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, %0d data errors, %0d protocol errors",
                 TIMEOUT_NS, data_errors, proto_errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hb937));
        clk          = 1'b0;
        rstn         = 1'b0;
        icache_req   = 1'b0;
        icache_addr  = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        dcache_wstrb = '0;
        d_addr       = '0;
        i_addr       = '0;
        cur_addr     = '0;
        d_read       = 1'b0;
        saw_mem_r    = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;
        check_idle(5);

        // cold miss and then a hit on the other half of the same L2 line
        access(1'b0, 1'b0, 32'h0000_0040, '0, '0);
        assert (saw_mem_r) else begin
            proto_errors++;
            $display("first read of a line was answered without a refill");
        end
        access(1'b0, 1'b0, 32'h0000_0058, '0, '0);
        assert (latency == 1 && !saw_mem_r) else begin
            proto_errors++;
            $display("read of a cached line was not a one-cycle hit (%0d cycles)", latency);
        end

        repeat (3) store_then_load();
        evict_set();
        dual_request(32'h0000_0048, 32'h0000_2060);
        random_mix(60);

        $display("reads checked %0d, writebacks %0d, data errors %0d, protocol errors %0d",
                 reads_checked, wb_count, data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
    input  logic          clk,
    input  logic          mem_req_r,
    input  logic [31:0]   mem_addr_r,
    output logic          mem_addr_ok_r,
    input  logic          mem_req_w,
    input  logic [31:0]   mem_addr_w,
    input  l2_pkg::line_t mem_wdata,
    output logic          mem_addr_ok_w,
    output logic          mem_data_ok,
    output l2_pkg::line_t mem_rdata
);
    // sparse store, only words that were written back
    logic [31:0] words [logic [31:0]];

    // every word depends on its full address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5ac3_0f1e;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return fill_word(addr);
    endfunction

    // one-cycle address accept after a random wait
    task automatic accept(input logic is_write);
        repeat ($urandom_range(3)) @(posedge clk);
        @(posedge clk);
        #2;
        if (is_write) begin
            mem_addr_ok_w = 1'b1;
        end else begin
            mem_addr_ok_r = 1'b1;
        end
        @(posedge clk);
        #2;
        mem_addr_ok_w = 1'b0;
        mem_addr_ok_r = 1'b0;
    endtask

    // data_ok pulse, some cycles after the accept
    task automatic return_line(input l2_pkg::line_t line);
        repeat ($urandom_range(4)) begin
            @(posedge clk);
            #2;
        end
        mem_rdata   = line;
        mem_data_ok = 1'b1;
        @(posedge clk);
        #2;
        mem_data_ok = 1'b0;
    endtask

    initial begin
        logic [31:0]   base;
        l2_pkg::line_t line;
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        forever begin
            @(negedge clk);
            if (mem_req_w) begin
                base = mem_addr_w;
                line = mem_wdata;
                for (int w = 0; w < 8; w++) begin
                    words[base + 32'(w * 4)] = line[w*32 +: 32];
                end
                accept(1'b1);
                return_line(line);
            end else if (mem_req_r) begin
                base = mem_addr_r;
                for (int w = 0; w < 8; w++) begin
                    line[w*32 +: 32] = read_word(base + 32'(w * 4));
                end
                accept(1'b0);
                return_line(line);
            end
        end
    end

endmodule
